//--- source/core_pkg.sv
//--------------------------------------------------------------------------
// Core package
// Shared widths, queue sizing, RV32 opcodes, message structs and the
// execute FSM encoding for the in-order core
//--------------------------------------------------------------------------

package core_pkg;

  // Data path widths
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     addr_t;
  typedef logic [4:0]      reg_idx_t;

  // Instruction queue sizing, depth must stay a power of two
  localparam int QUEUE_DEPTH = 4;
  localparam int QCNT_W      = 3;
  localparam int QPTR_W      = 2;

  typedef logic [QCNT_W-1:0] qcnt_t;
  typedef logic [QPTR_W-1:0] qptr_t;

  // Major opcodes of the supported subset
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;

  // Instruction class seen by the execute unit
  typedef logic [1:0] kind_t;
  localparam kind_t KIND_ALU   = 2'd0;
  localparam kind_t KIND_LOAD  = 2'd1;
  localparam kind_t KIND_STORE = 2'd2;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_RUN, ST_WAIT_LOAD, ST_HALTED
  } exec_state_e;

  //--------------------------------------------------------------------------
  // Messages
  //--------------------------------------------------------------------------

  typedef struct packed { addr_t addr; } imem_req_t;
  typedef struct packed { word_t data; } imem_resp_t;

  // Fetched word tagged with its address
  typedef struct packed {
    addr_t pc;
    word_t inst;
  } queue_entry_t;

  typedef struct packed {
    kind_t    kind;
    alu_op_e  alu_op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    logic     use_imm;
    logic     writes_rd;
    logic     illegal;
  } decoded_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } dmem_req_t;

  typedef struct packed { word_t rdata; } dmem_resp_t;

  // One record per retired instruction
  typedef struct packed {
    addr_t    pc;
    reg_idx_t waddr;
    word_t    wdata;
    logic     wen;
  } trace_t;

endpackage

//--- source/inst_decode.sv
//--------------------------------------------------------------------------
// Instruction decode
// Maps a 32-bit RV32 word onto the decoded-instruction struct, anything
// outside the supported subset is flagged illegal
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module inst_decode import core_pkg::*; (
  input  word_t    inst,
  output decoded_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Sign-extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    dec         = '0;
    dec.kind    = KIND_ALU;
    dec.alu_op  = ALU_ADD;
    dec.rd      = inst[11:7];
    dec.rs1     = inst[19:15];
    dec.rs2     = inst[24:20];
    dec.illegal = 1'b1;

    case (opcode)
      OP_IMM: begin
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.illegal = 1'b0;
        case (funct3)
          3'b000:  dec.alu_op = ALU_ADD;
          3'b100:  dec.alu_op = ALU_XOR;
          3'b110:  dec.alu_op = ALU_OR;
          3'b111:  dec.alu_op = ALU_AND;
          // Shifts and compares not supported
          default: dec.illegal = 1'b1;
        endcase
      end
      OP_REG: begin
        dec.illegal = 1'b0;
        case ({funct7, funct3})
          10'b0000000_000: dec.alu_op = ALU_ADD;
          10'b0100000_000: dec.alu_op = ALU_SUB;
          10'b0000000_100: dec.alu_op = ALU_XOR;
          10'b0000000_110: dec.alu_op = ALU_OR;
          10'b0000000_111: dec.alu_op = ALU_AND;
          default:         dec.illegal = 1'b1;
        endcase
      end
      OP_LUI: begin
        dec.alu_op  = ALU_PASS_B;
        dec.rs1     = '0;
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.illegal = 1'b0;
      end
      OP_LOAD: begin
        // Word loads only
        dec.kind    = KIND_LOAD;
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.illegal = (funct3 != 3'b010);
      end
      OP_STORE: begin
        dec.kind    = KIND_STORE;
        dec.imm     = imm_s;
        dec.use_imm = 1'b1;
        dec.illegal = (funct3 != 3'b010);
      end
      default: dec.illegal = 1'b1;
    endcase

    // No architectural write for stores, x0 targets or bad words
    dec.writes_rd = (dec.kind != KIND_STORE) && (dec.rd != '0) && !dec.illegal;
  end

endmodule

//--- source/inst_fetch.sv
//--------------------------------------------------------------------------
// Instruction fetch
// Issues sequential instruction-memory requests under a credit limit and
// tags each returning word with the PC it was fetched from
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module inst_fetch import core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  qcnt_t     free_slots,
  input  logic      imem_resp_val,
  input  logic      halt,
  output imem_req_t imem_req,
  output logic      imem_req_val,
  output addr_t     resp_pc
);

  addr_t next_pc;
  qcnt_t outstanding;
  logic  issue;

  // In-order PC FIFO, one entry per request in flight
  addr_t pc_fifo [QUEUE_DEPTH];
  qptr_t pc_wr_ptr;
  qptr_t pc_rd_ptr;

  // Credit check, in-flight words plus queued words never exceed depth
  assign issue   = !halt && (outstanding < free_slots);
  assign resp_pc = pc_fifo[pc_rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      next_pc      <= '0;
      outstanding  <= '0;
      pc_wr_ptr    <= '0;
      pc_rd_ptr    <= '0;
      imem_req_val <= 1'b0;
    end else begin
      imem_req_val <= issue;
      if (issue) begin
        next_pc   <= next_pc + 32'd4;
        pc_wr_ptr <= pc_wr_ptr + 1'b1;
      end
      if (imem_resp_val)
        pc_rd_ptr <= pc_rd_ptr + 1'b1;
      // Credit bookkeeping
      case ({issue, imem_resp_val})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // Request payload and PC tag
  always_ff @(posedge clk) begin
    if (issue) begin
      imem_req.addr      <= next_pc;
      pc_fifo[pc_wr_ptr] <= next_pc;
    end
  end

  // Credit counter stays bounded, and responses match requests
  assert property (@(posedge clk) disable iff (rst)
    outstanding <= qcnt_t'(QUEUE_DEPTH) && !(imem_resp_val && outstanding == '0))
    else $error("inst_fetch: credit count out of range or stray response");

endmodule

//--- source/inst_queue.sv
//--------------------------------------------------------------------------
// Instruction queue
// Circular FIFO of fetched words and their PCs that reports free slots
// back to fetch as credits
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module inst_queue import core_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         wr_val,
  input  queue_entry_t wr_entry,
  input  logic         pop,
  output queue_entry_t head,
  output logic         not_empty,
  output qcnt_t        free_slots
);

  queue_entry_t entries [QUEUE_DEPTH];
  qptr_t        wr_ptr;
  qptr_t        rd_ptr;
  qcnt_t        count;

  // Pointers wrap on their own since depth is a power of two
  assign head       = entries[rd_ptr];
  assign not_empty  = (count != '0);
  assign free_slots = qcnt_t'(QUEUE_DEPTH) - count;

  //--------------------------------------------------------------------------
  // Pointer and occupancy control
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_val)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      // Write and pop together leave count unchanged
      case ({wr_val, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (wr_val)
      entries[wr_ptr] <= wr_entry;
  end

  // Overflow would mean the fetch credits are wrong
  assert property (@(posedge clk) disable iff (rst)
    wr_val |-> (count != qcnt_t'(QUEUE_DEPTH)))
    else $error("inst_queue: write while full");

  assert property (@(posedge clk) disable iff (rst)
    pop |-> (count != '0))
    else $error("inst_queue: pop while empty");

endmodule

//--- source/exec_unit.sv
//--------------------------------------------------------------------------
// Execute unit
// Pops decoded work from the queue, runs the ALU and register file,
// drives data-memory requests and reports each retired instruction
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module exec_unit import core_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  queue_entry_t head,
  input  logic         not_empty,
  input  dmem_resp_t   dmem_resp,
  input  logic         dmem_resp_val,
  output logic         pop,
  output dmem_req_t    dmem_req,
  output logic         dmem_req_val,
  output trace_t       trace,
  output logic         trace_val,
  output logic         halt
);

  exec_state_e state;
  decoded_t    dec;

  word_t    regs [32];
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    alu_b;
  word_t    alu_result;

  // Pending load bookkeeping
  reg_idx_t ld_rd;
  addr_t    ld_pc;
  logic     ld_wen;

  logic     do_exec;
  logic     alu_done;
  logic     st_issue;
  logic     ld_issue;
  logic     ld_done;

  // Register file write port
  logic     rf_wen;
  reg_idx_t rf_waddr;
  word_t    rf_wdata;

  inst_decode u_decode (
    .inst (head.inst),
    .dec  (dec)
  );

  assign pop = (state == ST_RUN) && not_empty;

  // x0 always reads zero
  assign rs1_val = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
  assign rs2_val = (dec.rs2 == '0) ? '0 : regs[dec.rs2];
  assign alu_b   = dec.use_imm ? dec.imm : rs2_val;

  // Also forms load and store addresses
  always_comb begin
    case (dec.alu_op)
      ALU_SUB:    alu_result = rs1_val - alu_b;
      ALU_AND:    alu_result = rs1_val & alu_b;
      ALU_OR:     alu_result = rs1_val | alu_b;
      ALU_XOR:    alu_result = rs1_val ^ alu_b;
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = rs1_val + alu_b;
    endcase
  end

  assign do_exec  = pop && !dec.illegal;
  assign alu_done = do_exec && (dec.kind == KIND_ALU);
  assign st_issue = do_exec && (dec.kind == KIND_STORE);
  assign ld_issue = do_exec && (dec.kind == KIND_LOAD);
  assign ld_done  = (state == ST_WAIT_LOAD) && dmem_resp_val;

  assign rf_wen   = (alu_done && dec.writes_rd) || (ld_done && ld_wen);
  assign rf_waddr = ld_done ? ld_rd : dec.rd;
  assign rf_wdata = ld_done ? dmem_resp.rdata : alu_result;

  //--------------------------------------------------------------------------
  // FSM and strobes
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_RUN;
      trace_val    <= 1'b0;
      dmem_req_val <= 1'b0;
      halt         <= 1'b0;
    end else begin
      trace_val    <= alu_done || st_issue || ld_done;
      dmem_req_val <= st_issue || ld_issue;
      if (pop && dec.illegal) begin
        // Sticky until reset
        state <= ST_HALTED;
        halt  <= 1'b1;
      end else if (ld_issue) begin
        state <= ST_WAIT_LOAD;
      end else if (ld_done) begin
        state <= ST_RUN;
      end
    end
  end

  // Payload, register file and trace records
  always_ff @(posedge clk) begin
    if (rf_wen)
      regs[rf_waddr] <= rf_wdata;
    if (ld_issue) begin
      ld_rd  <= dec.rd;
      ld_pc  <= head.pc;
      ld_wen <= dec.writes_rd;
    end
    if (st_issue || ld_issue)
      dmem_req <= '{we: st_issue, addr: alu_result, wdata: st_issue ? rs2_val : '0};
    // Data field zeroed whenever wen is low
    if (ld_done)
      trace <= '{pc: ld_pc, waddr: ld_rd, wdata: ld_wen ? dmem_resp.rdata : '0, wen: ld_wen};
    else if (alu_done)
      trace <= '{pc: head.pc, waddr: dec.rd, wdata: dec.writes_rd ? alu_result : '0,
                 wen: dec.writes_rd};
    else if (st_issue)
      trace <= '{pc: head.pc, waddr: '0, wdata: '0, wen: 1'b0};
  end

  // Only loads get answered, and only one at a time
  assert property (@(posedge clk) disable iff (rst)
    dmem_resp_val |-> (state == ST_WAIT_LOAD))
    else $error("exec_unit: data response outside a pending load");

endmodule

//--- source/core_top.sv
//--------------------------------------------------------------------------
// Core top level
// Fetch, instruction queue and execute wired to the instruction memory,
// data memory and commit trace ports
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module core_top import core_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  output imem_req_t  imem_req,
  output logic       imem_req_val,
  input  imem_resp_t imem_resp,
  input  logic       imem_resp_val,
  output dmem_req_t  dmem_req,
  output logic       dmem_req_val,
  input  dmem_resp_t dmem_resp,
  input  logic       dmem_resp_val,
  output trace_t     trace,
  output logic       trace_val,
  output logic       halt
);

  qcnt_t        free_slots;
  addr_t        resp_pc;
  queue_entry_t wr_entry;
  queue_entry_t head;
  logic         not_empty;
  logic         pop;

  // Returning word joined with its fetch PC
  assign wr_entry = '{pc: resp_pc, inst: imem_resp.data};

  inst_fetch u_fetch (
    .clk           (clk),
    .rst           (rst),
    .free_slots    (free_slots),
    .imem_resp_val (imem_resp_val),
    .halt          (halt),
    .imem_req      (imem_req),
    .imem_req_val  (imem_req_val),
    .resp_pc       (resp_pc)
  );

  inst_queue u_queue (
    .clk        (clk),
    .rst        (rst),
    .wr_val     (imem_resp_val),
    .wr_entry   (wr_entry),
    .pop        (pop),
    .head       (head),
    .not_empty  (not_empty),
    .free_slots (free_slots)
  );

  exec_unit u_exec (
    .clk           (clk),
    .rst           (rst),
    .head          (head),
    .not_empty     (not_empty),
    .dmem_resp     (dmem_resp),
    .dmem_resp_val (dmem_resp_val),
    .pop           (pop),
    .dmem_req      (dmem_req),
    .dmem_req_val  (dmem_req_val),
    .trace         (trace),
    .trace_val     (trace_val),
    .halt          (halt)
  );

endmodule

//--- testbench/tb_core_model.svh
//--------------------------------------------------------------------------
// Core testbench model
// Memory images, xorshift generator and a sequential ISA model that builds
// random programs with their expected trace and data requests
//--------------------------------------------------------------------------

localparam logic [31:0] SEED       = 32'd61895;
localparam int          IMEM_WORDS = 64;
localparam int          DMEM_WORDS = 16;
localparam addr_t       DATA_BASE  = 32'h0000_0100;
localparam int          BODY_LEN   = 32;
// x1..x7 init, random body, closing illegal word
localparam int          PROG_LEN   = 7 + BODY_LEN + 1;

word_t       imem_arr   [IMEM_WORDS];
word_t       dmem_arr   [DMEM_WORDS];
word_t       model_mem  [DMEM_WORDS];
word_t       model_regs [32];
trace_t      exp_trace  [$];
dmem_req_t   exp_dmem   [$];
logic [31:0] gen_state;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s ^ (s << 13);
  x = x ^ (x >> 17);
  return x ^ (x << 5);
endfunction

function automatic logic [31:0] gen_rand();
  gen_state = xorshift32(gen_state);
  return gen_state;
endfunction

// Byte address to word slot of the data region
function automatic int data_index(input addr_t a);
  return int'((a - DATA_BASE) >> 2) & (DMEM_WORDS - 1);
endfunction

// Op numbers: 0 add, 1 sub, 2 xor, 3 or, 4 and
function automatic logic [2:0] funct3_of(input int op);
  case (op)
    2:       return 3'b100;
    3:       return 3'b110;
    4:       return 3'b111;
    default: return 3'b000;
  endcase
endfunction

function automatic word_t model_alu(input int op, input word_t a, input word_t b);
  case (op)
    1:       return a - b;
    2:       return a ^ b;
    3:       return a | b;
    4:       return a & b;
    default: return a + b;
  endcase
endfunction

//--------------------------------------------------------------------------
// Program generator, runs each instruction on the model as it is made
//--------------------------------------------------------------------------

task automatic build_program(input int mem_pct);
  logic [31:0] r;
  logic [31:0] q;
  logic [11:0] imm;
  logic [6:0]  f7;
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  word_t       a;
  word_t       b;
  word_t       bs;
  word_t       val;
  word_t       inst;
  addr_t       addr;
  logic        wen;
  int          pct;
  int          sel;
  exp_trace.delete();
  exp_dmem.delete();
  // All-zero word is illegal, so fetch past the end halts too
  foreach (imem_arr[i])
    imem_arr[i] = '0;
  foreach (dmem_arr[i]) begin
    r            = gen_rand();
    dmem_arr[i]  = r;
    model_mem[i] = r;
  end
  foreach (model_regs[i])
    model_regs[i] = '0;
  for (int i = 0; i < PROG_LEN - 1; i++) begin
    r    = gen_rand();
    q    = gen_rand();
    imm  = r[31:20];
    rd   = {2'b00, r[2:0]};
    rs1  = {2'b00, r[5:3]};
    rs2  = {2'b00, r[8:6]};
    a    = model_regs[rs1];
    b    = model_regs[rs2];
    bs   = {{20{imm[11]}}, imm};
    pct  = int'(r[15:9]) % 100;
    addr = DATA_BASE + {26'd0, q[3:0], 2'b00};
    val  = '0;
    wen  = (rd != 5'd0);
    if (i < 7) begin
      // addi xN, x0, imm
      rd   = reg_idx_t'(i + 1);
      wen  = 1'b1;
      inst = {imm, 5'd0, 3'b000, rd, OP_IMM};
      val  = bs;
    end else if (pct < mem_pct && q[4]) begin
      // lw with x0 base, so the immediate is the address
      inst = {addr[11:0], 5'd0, 3'b010, rd, OP_LOAD};
      val  = model_mem[data_index(addr)];
      exp_dmem.push_back(dmem_req_t'{we: 1'b0, addr: addr, wdata: 32'd0});
    end else if (pct < mem_pct) begin
      inst = {addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], OP_STORE};
      wen  = 1'b0;
      model_mem[data_index(addr)] = b;
      exp_dmem.push_back(dmem_req_t'{we: 1'b1, addr: addr, wdata: b});
    end else if (q[6:5] == 2'd0) begin
      inst = {r[31:12], rd, OP_LUI};
      val  = {r[31:12], 12'd0};
    end else if (q[6:5] == 2'd1) begin
      sel  = int'(q[9:7]) % 5;
      f7   = (sel == 1) ? 7'b0100000 : 7'b0000000;
      inst = {f7, rs2, rs1, funct3_of(sel), rd, OP_REG};
      val  = model_alu(sel, a, b);
    end else begin
      // Immediate forms have no subtract
      sel  = (q[8:7] == 2'd0) ? 0 : int'(q[8:7]) + 1;
      inst = {imm, rs1, funct3_of(sel), rd, OP_IMM};
      val  = model_alu(sel, a, bs);
    end
    imem_arr[i] = inst;
    if (wen)
      model_regs[rd] = val;
    exp_trace.push_back(trace_t'{pc: addr_t'(i * 4), waddr: wen ? rd : 5'd0,
                                 wdata: wen ? val : 32'd0, wen: wen});
  end
endtask

//--- testbench/tb_core.sv
//--------------------------------------------------------------------------
// Core testbench
// Random programs checked against a sequential ISA model, with in-order
// memory responders of random latency
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module tb_core import core_pkg::*; ();

  localparam int NUM_TESTS       = 4;
  localparam int CYCLES_PER_INST = 50;
  localparam int DRAIN_CYCLES    = 10;

  logic       clk;
  logic       rst;
  imem_req_t  imem_req;
  logic       imem_req_val;
  imem_resp_t imem_resp;
  logic       imem_resp_val;
  dmem_req_t  dmem_req;
  logic       dmem_req_val;
  dmem_resp_t dmem_resp;
  logic       dmem_resp_val;
  trace_t     trace;
  logic       trace_val;
  logic       halt;

  `include "tb_core_model.svh"

  // Run bookkeeping
  string cur_test;
  int    err_count;
  int    fail_tests;
  int    cycle;
  int    since_rst;
  logic  rst_q;
  logic  halt_q;
  logic  max_latency;
  addr_t exp_fetch;
  int    trace_idx;
  int    dmem_idx;

  // Responder queues, due cycle per request
  addr_t       imem_q_addr [$];
  int          imem_q_due  [$];
  int          imem_last_due;
  int          imem_due;
  logic [31:0] imem_lat_state;
  addr_t       dmem_q_addr [$];
  int          dmem_q_due  [$];
  int          dmem_last_due;
  int          dmem_due;
  logic [31:0] dmem_lat_state;

  core_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .imem_req      (imem_req),
    .imem_req_val  (imem_req_val),
    .imem_resp     (imem_resp),
    .imem_resp_val (imem_resp_val),
    .dmem_req      (dmem_req),
    .dmem_req_val  (dmem_req_val),
    .dmem_resp     (dmem_resp),
    .dmem_resp_val (dmem_resp_val),
    .trace         (trace),
    .trace_val     (trace_val),
    .halt          (halt)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  //--------------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------------

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", cur_test, msg);
    err_count++;
  endtask

  task automatic check_trace(input string what, input trace_t exp, input trace_t act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_dmem_req(input string what, input dmem_req_t exp, input dmem_req_t act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_halt(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %b actual %b", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  // Extra wait beyond the minimum one-cycle latency
  function automatic int extra_delay(input logic [31:0] st);
    return max_latency ? 3 : int'(st[1:0]);
  endfunction

  //--------------------------------------------------------------------------
  // Memory responders, in order, one response per cycle at most
  //--------------------------------------------------------------------------

  always @(posedge clk) begin
    imem_resp_val <= 1'b0;
    if (rst) begin
      imem_q_addr.delete();
      imem_q_due.delete();
      imem_last_due = 0;
    end else begin
      if (imem_req_val) begin
        imem_lat_state = xorshift32(imem_lat_state);
        imem_due       = cycle + extra_delay(imem_lat_state);
        if (imem_due <= imem_last_due)
          imem_due = imem_last_due + 1;
        imem_last_due = imem_due;
        imem_q_addr.push_back(imem_req.addr);
        imem_q_due.push_back(imem_due);
      end
      if (imem_q_due.size() > 0 && imem_q_due[0] <= cycle) begin
        imem_resp_val  <= 1'b1;
        imem_resp.data <= imem_arr[int'(imem_q_addr[0] >> 2) & (IMEM_WORDS - 1)];
        void'(imem_q_addr.pop_front());
        void'(imem_q_due.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    dmem_resp_val <= 1'b0;
    if (rst) begin
      dmem_q_addr.delete();
      dmem_q_due.delete();
      dmem_last_due = 0;
    end else begin
      // Stores land at once and get no answer
      if (dmem_req_val && dmem_req.we) begin
        dmem_arr[data_index(dmem_req.addr)] = dmem_req.wdata;
      end else if (dmem_req_val) begin
        dmem_lat_state = xorshift32(dmem_lat_state);
        dmem_due       = cycle + extra_delay(dmem_lat_state);
        if (dmem_due <= dmem_last_due)
          dmem_due = dmem_last_due + 1;
        dmem_last_due = dmem_due;
        dmem_q_addr.push_back(dmem_req.addr);
        dmem_q_due.push_back(dmem_due);
      end
      if (dmem_q_due.size() > 0 && dmem_q_due[0] <= cycle) begin
        dmem_resp_val   <= 1'b1;
        dmem_resp.rdata <= dmem_arr[data_index(dmem_q_addr[0])];
        void'(dmem_q_addr.pop_front());
        void'(dmem_q_due.pop_front());
      end
    end
  end

  //--------------------------------------------------------------------------
  // Output monitor
  //--------------------------------------------------------------------------

  always @(posedge clk) begin
    rst_q <= rst;
    if (rst) begin
      since_rst <= 0;
      halt_q    <= 1'b0;
      exp_fetch = '0;
      trace_idx = 0;
      dmem_idx  = 0;
      // Outputs settle after the first reset edge
      if (rst_q && (imem_req_val || dmem_req_val || trace_val || halt))
        report_error("strobe or halt active during reset");
    end else begin
      since_rst <= since_rst + 1;
      halt_q    <= halt;
      if (since_rst == 1 && imem_req_val !== 1'b1)
        report_error("no fetch request in the first cycle after reset");
      if (imem_req_val) begin
        if (halt_q)
          report_error("fetch request issued after halt");
        check_addr("fetch address", exp_fetch, imem_req.addr);
        exp_fetch = exp_fetch + 32'd4;
      end
      if (halt_q)
        check_halt("halt held", 1'b1, halt);
      if (halt && (trace_val || dmem_req_val))
        report_error("trace record or data request while halted");
      if (trace_val) begin
        if (trace_idx < exp_trace.size())
          check_trace($sformatf("trace[%0d]", trace_idx), exp_trace[trace_idx], trace);
        else
          report_error("trace record beyond the end of the program");
        trace_idx = trace_idx + 1;
      end
      if (dmem_req_val) begin
        if (dmem_idx < exp_dmem.size())
          check_dmem_req($sformatf("dmem[%0d]", dmem_idx), exp_dmem[dmem_idx], dmem_req);
        else
          report_error("unexpected data memory request");
        dmem_idx = dmem_idx + 1;
      end
    end
  end

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------

  task automatic run_test(input string name, input int mem_pct, input logic slow);
    int errs_before;
    errs_before = err_count;
    cur_test    = name;
    max_latency = slow;
    rst <= 1'b1;
    build_program(mem_pct);
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // Closing illegal word ends every program
    while (halt !== 1'b1)
      @(posedge clk);
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (trace_idx != exp_trace.size())
      report_error($sformatf("%0d trace records seen, %0d expected",
                             trace_idx, exp_trace.size()));
    if (dmem_idx != exp_dmem.size())
      report_error($sformatf("%0d data requests seen, %0d expected",
                             dmem_idx, exp_dmem.size()));
    check_halt("halt at end", 1'b1, halt);
    foreach (model_mem[i])
      check_word($sformatf("mem[%0d]", i), model_mem[i], dmem_arr[i]);
    if (err_count == errs_before) begin
      $display("PASS %s: %0d records, %0d data requests", name, trace_idx, dmem_idx);
    end else begin
      fail_tests++;
      $display("test %s failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  initial begin
    rst           <= 1'b1;
    imem_resp     <= '0;
    imem_resp_val <= 1'b0;
    dmem_resp     <= '0;
    dmem_resp_val <= 1'b0;
    err_count      = 0;
    fail_tests     = 0;
    max_latency    = 1'b0;
    gen_state      = SEED;
    imem_lat_state = xorshift32(SEED ^ 32'h5a5a_0000);
    dmem_lat_state = xorshift32(SEED ^ 32'h0000_a5a5);
    run_test("alu_mix", 10, 1'b0);
    run_test("load_store", 60, 1'b0);
    run_test("max_latency", 40, 1'b1);
    run_test("random_mix", 30, 1'b0);
    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, fail_tests, err_count);
    if (err_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Stall guard sized from the total instruction count
  initial begin
    repeat (NUM_TESTS * PROG_LEN * CYCLES_PER_INST) @(posedge clk);
    $display("ERROR %s: core stalled, no halt before the watchdog expired", cur_test);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- project.f
+incdir+testbench
source/core_pkg.sv
source/inst_decode.sv
source/inst_fetch.sv
source/inst_queue.sv
source/exec_unit.sv
source/core_top.sv
testbench/tb_core.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" &&
mkdir -p build &&
verilator --binary --timing --assert -j 0 -f project.f --top-module tb_core \
  -Mdir build -o sim_core &&
./build/sim_core > sim.log 2>&1 ||
{ echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
